// ==== hw/fetch_pkg.sv ====
/*
 * Shared constants of the instruction fetch subsystem: strand count, widths,
 * cache geometry, queue depth and reset PCs
 */
`default_nettype none

package fetch_pkg;

	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = $clog2(NUM_STRANDS);

	localparam int ADDR_W = 32; // Byte address
	localparam int DATA_W = 32; // One instruction word

	// Cache geometry
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = WORDS_PER_LINE * DATA_W;
	localparam int CACHE_LINES = 16;
	localparam int INDEX_W = $clog2(CACHE_LINES);
	localparam int WORD_OFF_W = $clog2(WORDS_PER_LINE);
	localparam int BYTE_OFF_W = $clog2(DATA_W / 8);
	localparam int OFFSET_W = WORD_OFF_W + BYTE_OFF_W; // Byte offset inside a line
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	localparam int FIFO_DEPTH = 4; // Entries per strand queue

	// Strand s starts at base + s * stride
	localparam logic [ADDR_W-1:0] RESET_PC_BASE = 32'h0000_0100;
	localparam logic [ADDR_W-1:0] RESET_PC_STRIDE = 32'h0000_0400;

endpackage

`default_nettype wire

// ==== hw/icache_if.sv ====
/*
 * Fetch stage to instruction cache connection, fetch and cache modports
 */
`timescale 1ns/1ns
`default_nettype none

interface icache_if;
	import fetch_pkg::*;

	logic request;
	logic [ADDR_W-1:0] addr;
	logic [STRAND_W-1:0] req_strand;
	logic [DATA_W-1:0] data; // Valid with hit, one cycle after request
	logic hit;
	logic [NUM_STRANDS-1:0] load_complete_strands; // One-cycle wakeup mask
	logic load_collision; // Miss on another line during a refill

	modport fetch (
		output request, addr, req_strand,
		input data, hit, load_complete_strands, load_collision
	);

	modport cache (
		input request, addr, req_strand,
		output data, hit, load_complete_strands, load_collision
	);

endinterface

`default_nettype wire

// ==== hw/strand_arbiter.sv ====
/*
 * Four-way arbiter with least-recently-granted ordering
 */
`timescale 1ns/1ns
`default_nettype none

module strand_arbiter (
	input logic clk,
	input logic rst_n_i,
	input logic [fetch_pkg::NUM_STRANDS-1:0] req_i,
	output logic [fetch_pkg::NUM_STRANDS-1:0] grant_o
);
	import fetch_pkg::*;

	// Strand indices, slot 0 is the least recently granted
	logic [NUM_STRANDS-1:0][STRAND_W-1:0] order_q;
	logic [STRAND_W-1:0] pick_pos;
	logic pick_valid;

	// First requester in age order wins
	always_comb
	begin
		grant_o = '0;
		pick_pos = '0;
		pick_valid = 1'b0;
		for (int p = 0; p < NUM_STRANDS; p++)
		begin
			if (!pick_valid && req_i[order_q[p]])
			begin
				pick_valid = 1'b1;
				pick_pos = STRAND_W'(p);
				grant_o[order_q[p]] = 1'b1;
			end
		end
	end

	// Winner moves to the most recent slot, the ones behind it shift up
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int p = 0; p < NUM_STRANDS; p++)
				order_q[p] <= STRAND_W'(p);
		end
		else if (pick_valid)
		begin
			for (int p = 0; p < NUM_STRANDS - 1; p++)
			begin
				if (p >= int'(pick_pos))
					order_q[p] <= order_q[p + 1];
			end
			order_q[NUM_STRANDS - 1] <= order_q[pick_pos];
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(grant_o) && ((grant_o & ~req_i) == '0));

endmodule

`default_nettype wire

// ==== hw/instruction_fifo.sv ====
/*
 * Synchronous circular queue with flush and an almost-full enqueue flag
 */
`timescale 1ns/1ns
`default_nettype none

module instruction_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n_i,
	input logic flush_i,
	input logic enqueue_i,
	input logic [WIDTH-1:0] value_i,
	input logic dequeue_i,
	output logic can_enqueue_o,
	output logic can_dequeue_o,
	output logic [WIDTH-1:0] value_o
);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(DEPTH+1)-1:0] count_q;
	logic do_enqueue;
	logic do_dequeue;

	assign do_enqueue = enqueue_i && !flush_i;
	assign do_dequeue = dequeue_i && !flush_i && (count_q != '0);

	// One slot kept free for a fill already in flight
	assign can_enqueue_o = int'(count_q) < DEPTH - 1;
	assign can_dequeue_o = count_q != '0;
	assign value_o = storage[rd_ptr_q]; // Head

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else if (flush_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_enqueue)
			begin
				if (int'(wr_ptr_q) == DEPTH - 1)
					wr_ptr_q <= '0;
				else
					wr_ptr_q <= wr_ptr_q + 1'b1;
			end

			if (do_dequeue)
			begin
				if (int'(rd_ptr_q) == DEPTH - 1)
					rd_ptr_q <= '0;
				else
					rd_ptr_q <= rd_ptr_q + 1'b1;
			end

			if (do_enqueue && !do_dequeue)
				count_q <= count_q + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[wr_ptr_q] <= value_i;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
		do_enqueue |-> int'(count_q) != DEPTH);

endmodule

`default_nettype wire

// ==== hw/instruction_fetch_stage.sv ====
/*
 * Strand PCs, cache wait tracking, strand arbitration, byte swap
 * and the per-strand instruction queues
 */
`timescale 1ns/1ns
`default_nettype none

module instruction_fetch_stage (
	input logic clk,
	input logic rst_n_i,
	icache_if.fetch cache_port,
	input logic [fetch_pkg::NUM_STRANDS-1:0] req_i,
	input logic [fetch_pkg::NUM_STRANDS-1:0] rollback_i,
	input logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::ADDR_W-1:0] rollback_pc_i,
	output logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::DATA_W-1:0] instr_o,
	output logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::ADDR_W-1:0] pc_o,
	output logic [fetch_pkg::NUM_STRANDS-1:0] valid_o
);
	import fetch_pkg::*;

	logic [NUM_STRANDS-1:0][ADDR_W-1:0] pc_q;
	logic [NUM_STRANDS-1:0][ADDR_W-1:0] pc_d;
	logic [NUM_STRANDS-1:0] grant;
	logic [NUM_STRANDS-1:0] grant_q; // Strand whose answer arrives this cycle
	logic [NUM_STRANDS-1:0] wait_q;
	logic [NUM_STRANDS-1:0] wait_d;
	logic [NUM_STRANDS-1:0] can_enqueue;
	logic [NUM_STRANDS-1:0] eligible;
	logic [NUM_STRANDS-1:0][ADDR_W+DATA_W-1:0] queue_head;
	logic [DATA_W-1:0] swapped_word;
	logic miss_wait;

	// Refill started or joined, strand sleeps until its wakeup
	assign miss_wait = (grant_q != '0) && !cache_port.hit && !cache_port.load_collision;

	always_comb
	begin
		wait_d = wait_q & ~cache_port.load_complete_strands;
		if (miss_wait)
			wait_d = wait_d | grant_q;
	end

	assign eligible = can_enqueue & ~wait_d;

	strand_arbiter u_arbiter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req_i(eligible),
		.grant_o(grant)
	);

	assign cache_port.request = |grant;

	// Next PC goes out so a strand can be granted in back-to-back cycles
	always_comb
	begin
		cache_port.addr = pc_d[0];
		cache_port.req_strand = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (grant[s])
			begin
				cache_port.addr = pc_d[s];
				cache_port.req_strand = STRAND_W'(s);
			end
		end
	end

	always_comb
	begin
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (rollback_i[s])
				pc_d[s] = rollback_pc_i[s];
			else if (cache_port.hit && grant_q[s])
				pc_d[s] = pc_q[s] + 32'd4;
			else
				pc_d[s] = pc_q[s];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_q[s] <= RESET_PC_BASE + ADDR_W'(s) * RESET_PC_STRIDE;
			grant_q <= '0;
			wait_q <= '0;
		end
		else
		begin
			pc_q <= pc_d;
			grant_q <= grant;
			wait_q <= wait_d;
		end
	end

	// Memory is big-endian, the queues hold little-endian words
	assign swapped_word = {cache_port.data[7:0], cache_port.data[15:8],
		cache_port.data[23:16], cache_port.data[31:24]};

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_strand
		// A hit in the rollback cycle belongs to the old stream
		instruction_fifo #(
			.WIDTH(ADDR_W + DATA_W),
			.DEPTH(FIFO_DEPTH)
		) u_queue (
			.clk(clk),
			.rst_n_i(rst_n_i),
			.flush_i(rollback_i[s]),
			.enqueue_i(cache_port.hit && grant_q[s] && !rollback_i[s]),
			.value_i({pc_q[s], swapped_word}),
			.dequeue_i(req_i[s] && valid_o[s]),
			.can_enqueue_o(can_enqueue[s]),
			.can_dequeue_o(valid_o[s]),
			.value_o(queue_head[s])
		);

		assign pc_o[s] = queue_head[s][ADDR_W+DATA_W-1:DATA_W];
		assign instr_o[s] = queue_head[s][DATA_W-1:0];

		a_rollback_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
			rollback_i[s] |-> rollback_pc_i[s] != '0);
	end

	a_hit_after_request: assert property (@(posedge clk) disable iff (!rst_n_i)
		cache_port.hit |-> $past(cache_port.request));

endmodule

`default_nettype wire

// ==== hw/instruction_cache.sv ====
/*
 * Direct-mapped instruction cache, registered lookup and a single line
 * refill engine on the external memory port
 */
`timescale 1ns/1ns
`default_nettype none

module instruction_cache (
	input logic clk,
	input logic rst_n_i,
	icache_if.cache cache_port,
	output logic mem_req_o,
	output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
	input logic mem_ack_i,
	input logic [fetch_pkg::LINE_W-1:0] mem_data_i
);
	import fetch_pkg::*;

	logic [TAG_W-1:0] tag_mem [CACHE_LINES];
	logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_mem [CACHE_LINES]; // Word 0 in low bits
	logic [CACHE_LINES-1:0] line_valid_q;

	logic req_valid_q;
	logic [ADDR_W-1:0] req_addr_q;
	logic [STRAND_W-1:0] req_strand_q;
	logic [INDEX_W-1:0] req_index;
	logic [WORD_OFF_W-1:0] req_word;
	logic [TAG_W-1:0] req_tag;

	logic refill_busy_q;
	logic [ADDR_W-1:0] refill_addr_q; // Line aligned
	logic [INDEX_W-1:0] refill_index;
	logic [NUM_STRANDS-1:0] waiters_q;
	logic [NUM_STRANDS-1:0] waiters_d;
	logic [NUM_STRANDS-1:0] complete_q;
	logic [NUM_STRANDS-1:0] strand_bit;
	logic lookup_hit;
	logic miss;
	logic same_line;

	assign req_word = req_addr_q[BYTE_OFF_W +: WORD_OFF_W];
	assign req_index = req_addr_q[OFFSET_W +: INDEX_W];
	assign req_tag = req_addr_q[ADDR_W-1 -: TAG_W];
	assign refill_index = refill_addr_q[OFFSET_W +: INDEX_W];

	// Arrays read with last cycle's address
	assign lookup_hit = req_valid_q && line_valid_q[req_index]
		&& (tag_mem[req_index] == req_tag);
	assign miss = req_valid_q && !lookup_hit;
	assign same_line = refill_addr_q[ADDR_W-1:OFFSET_W] == req_addr_q[ADDR_W-1:OFFSET_W];
	assign strand_bit = NUM_STRANDS'(1) << req_strand_q;

	// Miss on the line in flight just joins the waiters
	always_comb
	begin
		waiters_d = waiters_q;
		if (miss && refill_busy_q && same_line)
			waiters_d = waiters_q | strand_bit;
	end

	assign cache_port.hit = lookup_hit;
	assign cache_port.data = line_mem[req_index][req_word];
	assign cache_port.load_collision = miss && refill_busy_q && !same_line;
	assign cache_port.load_complete_strands = complete_q;

	assign mem_req_o = refill_busy_q;
	assign mem_addr_o = refill_addr_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			req_valid_q <= 1'b0;
			line_valid_q <= '0;
			refill_busy_q <= 1'b0;
			waiters_q <= '0;
			complete_q <= '0;
		end
		else
		begin
			req_valid_q <= cache_port.request;
			complete_q <= '0;
			if (refill_busy_q)
			begin
				if (mem_ack_i)
				begin
					refill_busy_q <= 1'b0;
					line_valid_q[refill_index] <= 1'b1;
					complete_q <= waiters_d; // Wakes late joiners too
					waiters_q <= '0;
				end
				else
				begin
					waiters_q <= waiters_d;
				end
			end
			else if (miss)
			begin
				refill_busy_q <= 1'b1;
				waiters_q <= strand_bit;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		req_addr_q <= cache_port.addr;
		req_strand_q <= cache_port.req_strand;
		if (!refill_busy_q && miss)
			refill_addr_q <= {req_addr_q[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
		if (refill_busy_q && mem_ack_i)
		begin
			tag_mem[refill_index] <= refill_addr_q[ADDR_W-1 -: TAG_W];
			line_mem[refill_index] <= mem_data_i;
		end
	end

	a_mem_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_req_o |-> mem_addr_o[OFFSET_W-1:0] == '0);

endmodule

`default_nettype wire

// ==== hw/fetch_unit_top.sv ====
/*
 * Fetch unit top level, fetch stage and instruction cache on plain ports
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_top (
	input logic clk,
	input logic rst_n_i,

	// Strand side
	input logic [fetch_pkg::NUM_STRANDS-1:0] req_i,
	input logic [fetch_pkg::NUM_STRANDS-1:0] rollback_i,
	input logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::ADDR_W-1:0] rollback_pc_i,
	output logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::DATA_W-1:0] instr_o,
	output logic [fetch_pkg::NUM_STRANDS-1:0][fetch_pkg::ADDR_W-1:0] pc_o,
	output logic [fetch_pkg::NUM_STRANDS-1:0] valid_o,

	// Memory side, one line per ack
	output logic mem_req_o,
	output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
	input logic mem_ack_i,
	input logic [fetch_pkg::LINE_W-1:0] mem_data_i
);

	icache_if u_cache_bus ();

	instruction_fetch_stage u_fetch_stage (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.cache_port(u_cache_bus.fetch),
		.req_i(req_i),
		.rollback_i(rollback_i),
		.rollback_pc_i(rollback_pc_i),
		.instr_o(instr_o),
		.pc_o(pc_o),
		.valid_o(valid_o)
	);

	instruction_cache u_icache (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.cache_port(u_cache_bus.cache),
		.mem_req_o(mem_req_o),
		.mem_addr_o(mem_addr_o),
		.mem_ack_i(mem_ack_i),
		.mem_data_i(mem_data_i)
	);

endmodule

`default_nettype wire

// ==== verification/tb_fetch_unit.sv ====
/*
 * Fetch unit testbench: random strand traffic, line memory responder,
 * per-strand PC model, checks and watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_unit;
	import fetch_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int MEM_WORDS = 4096; // Addresses wrap at 16 KB
	localparam int MEM_AW = $clog2(MEM_WORDS);
	localparam int WORST_REFILL = 7; // Ack delay plus miss and wakeup cycles
	localparam int SEQ_TARGET = 24;
	localparam int BP_TARGET = 24;
	localparam int RB_TARGET = 32;
	localparam int MIN_PROGRESS = 16;
	localparam int CYCLES_PER_INSTR = 2 * NUM_STRANDS * WORST_REFILL;
	localparam int WATCHDOG_CYCLES =
		(SEQ_TARGET + BP_TARGET + RB_TARGET + MIN_PROGRESS) * CYCLES_PER_INSTR + 500;

	logic clk;
	logic rst_n_i;
	logic [NUM_STRANDS-1:0] req_i;
	logic [NUM_STRANDS-1:0] rollback_i;
	logic [NUM_STRANDS-1:0][ADDR_W-1:0] rollback_pc_i;
	logic [NUM_STRANDS-1:0][DATA_W-1:0] instr_o;
	logic [NUM_STRANDS-1:0][ADDR_W-1:0] pc_o;
	logic [NUM_STRANDS-1:0] valid_o;
	logic mem_req_o;
	logic [ADDR_W-1:0] mem_addr_o;
	logic mem_ack_i;
	logic [LINE_W-1:0] mem_data_i;

	logic [DATA_W-1:0] mem [MEM_WORDS]; // Big-endian words
	logic [ADDR_W-1:0] exp_pc [NUM_STRANDS];
	logic held [NUM_STRANDS]; // Head must stay put next cycle
	logic [ADDR_W-1:0] held_pc [NUM_STRANDS];
	logic [DATA_W-1:0] held_instr [NUM_STRANDS];
	int stretch [NUM_STRANDS];
	int delivered [NUM_STRANDS];
	int err_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int refills = 0;
	int misaligned = 0;
	int rollbacks = 0;

	fetch_unit_top u_dut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req_i(req_i),
		.rollback_i(rollback_i),
		.rollback_pc_i(rollback_pc_i),
		.instr_o(instr_o),
		.pc_o(pc_o),
		.valid_o(valid_o),
		.mem_req_o(mem_req_o),
		.mem_addr_o(mem_addr_o),
		.mem_ack_i(mem_ack_i),
		.mem_data_i(mem_data_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
		return mem[addr[2 +: MEM_AW]];
	endfunction

	function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			err_count++;
			$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (err_count == errors_before)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, err_count - errors_before);
		end
	endtask

	// One line per ack, answered 1 to 5 cycles after the request is seen
	always
	begin : responder
		int delay;
		logic [LINE_W-1:0] line;
		@(posedge clk);
		if (rst_n_i && mem_req_o)
		begin
			refills++;
			if (mem_addr_o[OFFSET_W-1:0] != '0)
				misaligned++;
			check_value("mem_addr_o line offset", '0, mem_addr_o[OFFSET_W-1:0]);
			delay = 1 + $urandom % 5;
			repeat (delay - 1) @(posedge clk);
			for (int w = 0; w < WORDS_PER_LINE; w++)
				line[w*DATA_W +: DATA_W] = mem_word(mem_addr_o + ADDR_W'(w * 4));
			mem_data_i <= line;
			mem_ack_i <= 1'b1;
			@(posedge clk);
			mem_ack_i <= 1'b0;
		end
	end

	// Mode 0 all requesting, 1 long request stretches, 2 random with rollbacks
	task automatic drive_inputs(input int mode);
		logic [NUM_STRANDS-1:0] req_next;
		logic [NUM_STRANDS-1:0] rb_next;
		logic [NUM_STRANDS-1:0][ADDR_W-1:0] pc_next;
		pc_next = rollback_pc_i;
		rb_next = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (mode == 0)
				req_next[s] = 1'b1;
			else if (mode == 1)
			begin
				if (stretch[s] == 0)
				begin
					req_next[s] = !req_i[s];
					stretch[s] = req_next[s] ? 1 + $urandom % 6 : 1 + $urandom % 24;
				end
				else
				begin
					req_next[s] = req_i[s];
					stretch[s]--;
				end
			end
			else
			begin
				req_next[s] = ($urandom % 4) != 0;
				if ($urandom % 32 == 0)
				begin
					rb_next[s] = 1'b1;
					pc_next[s] = ADDR_W'(1 + $urandom % (MEM_WORDS - 1)) << 2; // Never zero
					rollbacks++;
				end
			end
		end
		req_i <= req_next;
		rollback_i <= rb_next;
		rollback_pc_i <= pc_next;
	endtask

	// Outputs are read before this edge's updates land
	task automatic step(input int mode);
		@(posedge clk);
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (held[s])
			begin
				check_value($sformatf("valid_o[%0d] while held", s), 1, valid_o[s]);
				check_value($sformatf("pc_o[%0d] while held", s), held_pc[s], pc_o[s]);
				check_value($sformatf("instr_o[%0d] while held", s), held_instr[s], instr_o[s]);
			end
			if (rollback_i[s])
				exp_pc[s] = rollback_pc_i[s]; // Flush wins over dequeue
			else if (valid_o[s] && req_i[s])
			begin
				check_value($sformatf("pc_o[%0d]", s), exp_pc[s], pc_o[s]);
				check_value($sformatf("instr_o[%0d]", s), swap_bytes(mem_word(exp_pc[s])),
					instr_o[s]);
				exp_pc[s] = exp_pc[s] + 32'd4;
				delivered[s]++;
			end
			held[s] = valid_o[s] && !req_i[s] && !rollback_i[s];
			held_pc[s] = pc_o[s];
			held_instr[s] = instr_o[s];
		end
		drive_inputs(mode);
	endtask

	// Runs until every strand has delivered target entries
	task automatic run_phase(input string name, input int mode, input int target);
		int cycles;
		bit done;
		cycles = 0;
		done = 1'b0;
		for (int s = 0; s < NUM_STRANDS; s++)
			delivered[s] = 0;
		while (!done && cycles < target * CYCLES_PER_INSTR)
		begin
			step(mode);
			cycles++;
			done = 1'b1;
			for (int s = 0; s < NUM_STRANDS; s++)
				if (delivered[s] < target)
					done = 1'b0;
		end
		if (!done)
		begin
			err_count++;
			$display("%s: a strand stopped delivering instructions after %0d cycles",
				name, cycles);
		end
	endtask

	initial
	begin : main
		int start;
		void'($urandom(32'h10b8_9c4e));
		rst_n_i <= 1'b0;
		req_i <= '0;
		rollback_i <= '0;
		rollback_pc_i <= '0;
		mem_ack_i <= 1'b0;
		mem_data_i <= '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = $urandom;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			exp_pc[s] = RESET_PC_BASE + ADDR_W'(s) * RESET_PC_STRIDE;
			held[s] = 1'b0;
			stretch[s] = 0;
		end
		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;

		@(posedge clk);
		start = err_count;
		check_value("valid_o", '0, valid_o);
		check_value("mem_req_o", '0, mem_req_o);
		report_test("Test 1 reset state", start);
		drive_inputs(0);

		start = err_count;
		run_phase("Test 2 sequential stream", 0, SEQ_TARGET);
		report_test("Test 2 sequential stream", start);

		start = err_count;
		run_phase("Test 4 back-pressure", 1, BP_TARGET);
		report_test("Test 4 back-pressure", start);

		start = err_count;
		run_phase("Test 5 rollback", 2, RB_TARGET);
		if (rollbacks == 0)
		begin
			err_count++;
			$display("Test 5 rollback: no rollback was issued");
		end
		report_test("Test 5 rollback", start);

		start = err_count;
		run_phase("Test 6 progress", 0, MIN_PROGRESS);
		report_test("Test 6 progress", start);

		start = err_count;
		check_value("misaligned refill count", 0, misaligned);
		if (refills == 0)
		begin
			err_count++;
			$display("Test 3 memory port: no refill was seen on the memory port");
		end
		report_test("Test 3 memory port", start);

		$display("Tests run %0d, failed %0d, errors %0d, refills %0d, rollbacks %0d",
			tests_run, tests_failed, err_count, refills, rollbacks);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the fetch unit stopped making progress",
			WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/fetch_pkg.sv
hw/icache_if.sv
hw/strand_arbiter.sv
hw/instruction_fifo.sv
hw/instruction_fetch_stage.sv
hw/instruction_cache.sv
hw/fetch_unit_top.sv
verification/tb_fetch_unit.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/icache_if.sv
      - hw/strand_arbiter.sv
      - hw/instruction_fifo.sv
      - hw/instruction_fetch_stage.sv
      - hw/instruction_cache.sv
      - hw/fetch_unit_top.sv
  - target: test
    files:
      - verification/tb_fetch_unit.sv
